//--- verilog.f
src/mcu_pkg.sv
src/accum_cpu.sv
src/program_rom.sv
src/data_ram.sv
src/gpio_port.sv
src/system_bus.sv
src/mcu_top.sv
tb/tb_clock.sv
tb/tb_mcu.sv

//--- tb/tb_mcu.sv
module tb_mcu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 200;

    logic        clk;
    logic        reset;
    logic [15:0] gpi;
    logic        debug;
    logic        quit;
    logic [15:0] gpo;

    int check_errors;
    int timeout_errors;

    // expected gpo bytes of the most recent case
    mcu_pkg::word_t last_sum;
    mcu_pkg::word_t last_diff;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    mcu_top #(.ram_addr_bits(6)) u_dut (
        .clk   (clk),
        .reset (reset),
        .gpi   (gpi),
        .debug (debug),
        .quit  (quit),
        .gpo   (gpo)
    );

    task automatic check_word(input string name, input mcu_pkg::word_t actual,
                              input mcu_pkg::word_t expected);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
                     $time, name, actual, expected);
        end
    endtask

    // outputs are sampled on the falling edge, away from register updates
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            timeout_errors++;
            $display("timeout: reset still high after %0d cycles", timeout_cycles);
        end
    endtask

    task automatic wait_debug_pulse();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!debug && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!debug) begin
            timeout_errors++;
            $display("timeout: no debug pulse within %0d cycles at %0t", timeout_cycles, $time);
        end
    endtask

    task automatic wait_quit();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!quit && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!quit) begin
            timeout_errors++;
            $display("timeout: quit not raised within %0d cycles at %0t", timeout_cycles, $time);
        end
    endtask

    // second pulse ends a pass that read the new gpi from its start
    task automatic run_gpio_case(input mcu_pkg::word_t lo, input mcu_pkg::word_t hi);
        mcu_pkg::word_t exp_sum;
        mcu_pkg::word_t exp_diff;
        exp_sum   = lo + hi;
        exp_diff  = lo - hi;
        last_sum  = exp_sum;
        last_diff = exp_diff;
        @(posedge clk);
        gpi <= {hi, lo};
        wait_debug_pulse();
        wait_debug_pulse();
        check_word("gpo[7:0]", gpo[7:0], exp_sum);
        check_word("gpo[15:8]", gpo[15:8], exp_diff);
        check_flag("quit", quit, 1'b0);
    endtask

    task automatic test_after_reset();
        wait_reset_release();
        check_word("gpo[7:0]", gpo[7:0], 8'h00);
        check_word("gpo[15:8]", gpo[15:8], 8'h00);
        check_flag("quit", quit, 1'b0);
        // first dbg is more than 40 cycles in
        repeat (20) begin
            check_flag("debug", debug, 1'b0);
            @(negedge clk);
        end
        wait_debug_pulse();
        // first pass ran with gpi 0x0101, both stores done before dbg
        check_word("gpo[7:0]", gpo[7:0], 8'h02);
        check_word("gpo[15:8]", gpo[15:8], 8'h00);
        check_flag("quit", quit, 1'b0);
    endtask

    task automatic test_fixed_values();
        run_gpio_case(8'h12, 8'h34);
        run_gpio_case(8'h80, 8'h01);
        run_gpio_case(8'h55, 8'hAA);
        run_gpio_case(8'h01, 8'h01);
    endtask

    task automatic test_random_values();
        mcu_pkg::word_t lo;
        mcu_pkg::word_t hi;
        repeat (20) begin
            lo = mcu_pkg::word_t'($urandom);
            // high byte kept in 1 to 255
            hi = mcu_pkg::word_t'($urandom % 255) + 8'd1;
            run_gpio_case(lo, hi);
        end
    endtask

    task automatic test_edge_values();
        run_gpio_case(8'hFF, 8'h01);
        run_gpio_case(8'h00, 8'hFF);
    endtask

    // gpo keeps the result of the last full pass
    task automatic test_quit_halts();
        @(posedge clk);
        gpi <= {8'h00, 8'h5A};
        wait_quit();
        repeat (50) begin
            @(negedge clk);
            check_flag("debug", debug, 1'b0);
            check_flag("quit", quit, 1'b1);
            check_word("gpo[7:0]", gpo[7:0], last_sum);
            check_word("gpo[15:8]", gpo[15:8], last_diff);
        end
    endtask

    initial begin
        void'($urandom(27));
        check_errors   = 0;
        timeout_errors = 0;
        last_sum       = '0;
        last_diff      = '0;
        // non-zero high byte so the program runs out of reset
        gpi = 16'h0101;

        test_after_reset();
        test_fixed_values();
        test_random_values();
        test_edge_values();
        test_quit_halts();

        $display("errors: %0d value mismatches, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- src/mcu_top.sv
module mcu_top #(
    parameter int ram_addr_bits = 6
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] gpi,
    output logic        debug,
    output logic        quit,
    output logic [15:0] gpo
);

    // system bus
    mcu_pkg::addr_t bus_addr;
    mcu_pkg::word_t bus_wdata;
    mcu_pkg::word_t bus_rdata;
    logic           bus_we;

    // slave selects and read data
    logic           rom_sel;
    logic           ram_sel;
    logic           gpio_sel;
    mcu_pkg::word_t rom_rdata;
    mcu_pkg::word_t ram_rdata;
    mcu_pkg::word_t gpio_rdata;

    accum_cpu u_cpu (
        .clk       (clk),
        .reset     (reset),
        .bus_rdata (bus_rdata),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_we    (bus_we),
        .debug     (debug),
        .quit      (quit)
    );

    system_bus #(.ram_addr_bits(ram_addr_bits)) u_bus (
        .clk        (clk),
        .reset      (reset),
        .bus_addr   (bus_addr),
        .rom_sel    (rom_sel),
        .ram_sel    (ram_sel),
        .gpio_sel   (gpio_sel),
        .rom_rdata  (rom_rdata),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .bus_rdata  (bus_rdata)
    );

    // 0x00 to 0x7f, gpio program
    program_rom u_rom (
        .clk     (clk),
        .rom_sel (rom_sel),
        .addr    (bus_addr),
        .data    (rom_rdata)
    );

    // 0x80 to 0xbf
    data_ram #(.ram_addr_bits(ram_addr_bits)) u_ram (
        .clk     (clk),
        .ram_sel (ram_sel),
        .addr    (bus_addr),
        .wdata   (bus_wdata),
        .we      (bus_we),
        .rdata   (ram_rdata)
    );

    // 0xf0 to 0xf3
    gpio_port u_gpio (
        .clk      (clk),
        .reset    (reset),
        .gpio_sel (gpio_sel),
        .addr     (bus_addr),
        .wdata    (bus_wdata),
        .we       (bus_we),
        .rdata    (gpio_rdata),
        .gpi      (gpi),
        .gpo      (gpo)
    );

endmodule

//--- src/system_bus.sv
module system_bus #(
    parameter int ram_addr_bits = 6
) (
    input  logic           clk,
    input  logic           reset,
    input  mcu_pkg::addr_t bus_addr,
    output logic           rom_sel,
    output logic           ram_sel,
    output logic           gpio_sel,
    input  mcu_pkg::word_t rom_rdata,
    input  mcu_pkg::word_t ram_rdata,
    input  mcu_pkg::word_t gpio_rdata,
    output mcu_pkg::word_t bus_rdata
);

    localparam int ram_depth = 2 ** ram_addr_bits;

    mcu_pkg::addr_t ram_offset;
    logic           rom_q;
    logic           ram_q;
    logic           gpio_q;

    assign ram_offset = bus_addr - mcu_pkg::ram_base;

    // window decode
    assign rom_sel  = (bus_addr >= mcu_pkg::rom_base) && (bus_addr <= mcu_pkg::rom_limit);
    // a smaller ram leaves the top of its window unmapped
    assign ram_sel  = (bus_addr >= mcu_pkg::ram_base) && (bus_addr <= mcu_pkg::ram_limit)
                   && (int'(ram_offset) < ram_depth);
    assign gpio_sel = (bus_addr >= mcu_pkg::gpi_lo_addr) && (bus_addr <= mcu_pkg::gpo_hi_addr);

    // which slave answers this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rom_q  <= 1'b0;
            ram_q  <= 1'b0;
            gpio_q <= 1'b0;
        end else begin
            rom_q  <= rom_sel;
            ram_q  <= ram_sel;
            gpio_q <= gpio_sel;
        end
    end

    always_comb begin
        if (rom_q) begin
            bus_rdata = rom_rdata;
        end else if (ram_q) begin
            bus_rdata = ram_rdata;
        end else if (gpio_q) begin
            bus_rdata = gpio_rdata;
        end else begin
            // unmapped reads zero
            bus_rdata = '0;
        end
    end

endmodule

//--- src/gpio_port.sv
module gpio_port (
    input  logic           clk,
    input  logic           reset,
    input  logic           gpio_sel,
    input  mcu_pkg::addr_t addr,
    input  mcu_pkg::word_t wdata,
    input  logic           we,
    output mcu_pkg::word_t rdata,
    input  logic [15:0]    gpi,
    output logic [15:0]    gpo
);

    logic [15:0]    gpi_q;
    mcu_pkg::word_t gpo_lo;
    mcu_pkg::word_t gpo_hi;

    // input sampling every cycle
    always_ff @(posedge clk) begin
        gpi_q <= gpi;
    end

    // output byte registers
    always_ff @(posedge clk) begin
        if (reset) begin
            gpo_lo <= '0;
            gpo_hi <= '0;
        end else if (gpio_sel && we) begin
            if (addr == mcu_pkg::gpo_lo_addr) begin
                gpo_lo <= wdata;
            end
            if (addr == mcu_pkg::gpo_hi_addr) begin
                gpo_hi <= wdata;
            end
        end
    end

    // outputs read back as well
    always_ff @(posedge clk) begin
        if (gpio_sel) begin
            case (addr)
                mcu_pkg::gpi_lo_addr: rdata <= gpi_q[7:0];
                mcu_pkg::gpi_hi_addr: rdata <= gpi_q[15:8];
                mcu_pkg::gpo_lo_addr: rdata <= gpo_lo;
                mcu_pkg::gpo_hi_addr: rdata <= gpo_hi;
                default:              rdata <= '0;
            endcase
        end
    end

    assign gpo = {gpo_hi, gpo_lo};

endmodule

//--- src/data_ram.sv
module data_ram #(
    parameter int ram_addr_bits = 6
) (
    input  logic           clk,
    input  logic           ram_sel,
    input  mcu_pkg::addr_t addr,
    input  mcu_pkg::word_t wdata,
    input  logic           we,
    output mcu_pkg::word_t rdata
);

    localparam int depth = 2 ** ram_addr_bits;

    mcu_pkg::word_t               mem [depth];
    logic [ram_addr_bits-1:0]     index;

    // window offset, only the low bits matter
    assign index = addr[ram_addr_bits-1:0];

    always_ff @(posedge clk) begin
        if (ram_sel) begin
            if (we) begin
                mem[index] <= wdata;
            end
            // read returns the old contents on a write cycle
            rdata <= mem[index];
        end
    end

endmodule

//--- src/program_rom.sv
module program_rom (
    input  logic           clk,
    input  logic           rom_sel,
    input  mcu_pkg::addr_t addr,
    output mcu_pkg::word_t data
);

    // loop entry and the quit instruction at the end
    localparam mcu_pkg::addr_t loop_start = mcu_pkg::rom_base;
    localparam mcu_pkg::addr_t halt_at    = 8'h16;

    // ram cell holding the high byte of gpi
    localparam mcu_pkg::addr_t temp_addr  = mcu_pkg::ram_base;

    mcu_pkg::word_t rom_byte;

    always_comb begin
        case (addr)
            8'h00: rom_byte = {4'h0, mcu_pkg::op_ld};
            8'h01: rom_byte = mcu_pkg::gpi_hi_addr;
            8'h02: rom_byte = {4'h0, mcu_pkg::op_st};
            8'h03: rom_byte = temp_addr;
            // zero high byte ends the program
            8'h04: rom_byte = {4'h0, mcu_pkg::op_jz};
            8'h05: rom_byte = halt_at;
            8'h06: rom_byte = {4'h0, mcu_pkg::op_ld};
            8'h07: rom_byte = mcu_pkg::gpi_lo_addr;
            8'h08: rom_byte = {4'h0, mcu_pkg::op_add};
            8'h09: rom_byte = temp_addr;
            8'h0A: rom_byte = {4'h0, mcu_pkg::op_st};
            8'h0B: rom_byte = mcu_pkg::gpo_lo_addr;
            // lo minus hi into the high output byte
            8'h0C: rom_byte = {4'h0, mcu_pkg::op_ld};
            8'h0D: rom_byte = mcu_pkg::gpi_lo_addr;
            8'h0E: rom_byte = {4'h0, mcu_pkg::op_sub};
            8'h0F: rom_byte = temp_addr;
            8'h10: rom_byte = {4'h0, mcu_pkg::op_st};
            8'h11: rom_byte = mcu_pkg::gpo_hi_addr;
            8'h12: rom_byte = {4'h0, mcu_pkg::op_dbg};
            8'h13: rom_byte = 8'h00;
            8'h14: rom_byte = {4'h0, mcu_pkg::op_jmp};
            8'h15: rom_byte = loop_start;
            8'h16: rom_byte = {4'h0, mcu_pkg::op_quit};
            8'h17: rom_byte = 8'h00;
            default: rom_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rom_sel) begin
            data <= rom_byte;
        end
    end

endmodule

//--- src/accum_cpu.sv
module accum_cpu (
    input  logic           clk,
    input  logic           reset,
    input  mcu_pkg::word_t bus_rdata,
    output mcu_pkg::addr_t bus_addr,
    output mcu_pkg::word_t bus_wdata,
    output logic           bus_we,
    output logic           debug,
    output logic           quit
);

    mcu_pkg::cpu_state_e state;
    mcu_pkg::addr_t      pc;
    mcu_pkg::opcode_e    opcode;
    mcu_pkg::word_t      operand;
    mcu_pkg::word_t      acc;

    logic                acc_zero;

    assign acc_zero = (acc == '0);

    // state machine and program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mcu_pkg::st_op_addr;
            pc    <= '0;
        end else begin
            case (state)
                mcu_pkg::st_op_addr: begin
                    // opcode byte address is on the bus
                    pc    <= pc + 8'd1;
                    state <= mcu_pkg::st_op_data;
                end
                mcu_pkg::st_op_data: begin
                    // operand byte address is on the bus
                    pc    <= pc + 8'd1;
                    state <= mcu_pkg::st_arg_data;
                end
                mcu_pkg::st_arg_data: begin
                    state <= mcu_pkg::st_exec;
                end
                mcu_pkg::st_exec: begin
                    case (opcode)
                        mcu_pkg::op_ld,
                        mcu_pkg::op_add,
                        mcu_pkg::op_sub: begin
                            state <= mcu_pkg::st_mem_data;
                        end
                        mcu_pkg::op_jz: begin
                            if (acc_zero) begin
                                pc <= operand;
                            end
                            state <= mcu_pkg::st_op_addr;
                        end
                        mcu_pkg::op_jmp: begin
                            pc    <= operand;
                            state <= mcu_pkg::st_op_addr;
                        end
                        mcu_pkg::op_quit: begin
                            state <= mcu_pkg::st_halt;
                        end
                        default: begin
                            // ldi, st, dbg and unknown opcodes
                            state <= mcu_pkg::st_op_addr;
                        end
                    endcase
                end
                mcu_pkg::st_mem_data: begin
                    state <= mcu_pkg::st_op_addr;
                end
                mcu_pkg::st_halt: begin
                    // stays here until reset
                    state <= mcu_pkg::st_halt;
                end
                default: begin
                    state <= mcu_pkg::st_op_addr;
                end
            endcase
        end
    end

    // instruction and accumulator registers
    always_ff @(posedge clk) begin
        case (state)
            mcu_pkg::st_op_data: begin
                opcode <= mcu_pkg::opcode_e'(bus_rdata[3:0]);
            end
            mcu_pkg::st_arg_data: begin
                operand <= bus_rdata;
            end
            mcu_pkg::st_exec: begin
                if (opcode == mcu_pkg::op_ldi) begin
                    acc <= operand;
                end
            end
            mcu_pkg::st_mem_data: begin
                case (opcode)
                    mcu_pkg::op_ld:  acc <= bus_rdata;
                    mcu_pkg::op_add: acc <= acc + bus_rdata;
                    mcu_pkg::op_sub: acc <= acc - bus_rdata;
                    default:         acc <= acc;
                endcase
            end
            default: begin
                acc <= acc;
            end
        endcase
    end

    // operand address during execute and memory data, pc otherwise
    always_comb begin
        bus_addr = pc;
        if (state == mcu_pkg::st_exec) begin
            bus_addr = operand;
        end else if (state == mcu_pkg::st_mem_data) begin
            bus_addr = operand;
        end
    end

    assign bus_wdata = acc;
    assign bus_we    = (state == mcu_pkg::st_exec) && (opcode == mcu_pkg::op_st);

    // one cycle pulse during the execute cycle of dbg
    assign debug = (state == mcu_pkg::st_exec) && (opcode == mcu_pkg::op_dbg);

    // high from the cycle after quit executes
    assign quit = (state == mcu_pkg::st_halt);

endmodule

//--- src/mcu_pkg.sv
package mcu_pkg;

    // data word and bus address
    typedef logic [7:0] word_t;
    typedef logic [7:0] addr_t;

    // opcode sits in the low nibble of the first instruction byte
    typedef enum logic [3:0] {
        op_ldi  = 4'h0,
        op_ld   = 4'h1,
        op_st   = 4'h2,
        op_add  = 4'h3,
        op_sub  = 4'h4,
        op_jz   = 4'h5,
        op_jmp  = 4'h6,
        op_dbg  = 4'h7,
        op_quit = 4'h8
    } opcode_e;

    typedef enum logic [2:0] {
        st_op_addr,
        st_op_data,
        st_arg_data,
        st_exec,
        st_mem_data,
        st_halt
    } cpu_state_e;

    // memory map
    localparam addr_t rom_base    = 8'h00;
    localparam addr_t rom_limit   = 8'h7F;
    localparam addr_t ram_base    = 8'h80;
    localparam addr_t ram_limit   = 8'hBF;
    localparam addr_t gpi_lo_addr = 8'hF0;
    localparam addr_t gpi_hi_addr = 8'hF1;
    localparam addr_t gpo_lo_addr = 8'hF2;
    localparam addr_t gpo_hi_addr = 8'hF3;

endpackage
